/* sources.f */
design/cmd_pkg.sv
design/msg_if.sv
design/reply_if.sv
design/ascii_hex_decode.sv
design/ascii_hex_encode.sv
design/msg_parser.sv
design/cmd_exec.sv
design/reply_sender.sv
design/cmd_decode_top.sv
verif/tb_clock_gen.sv
verif/tb_cmd_decode.sv

/* Bender.yml */
package:
  name: cmd_decode

sources:
  - design/cmd_pkg.sv
  - design/msg_if.sv
  - design/reply_if.sv
  - design/ascii_hex_decode.sv
  - design/ascii_hex_encode.sv
  - design/msg_parser.sv
  - design/cmd_exec.sv
  - design/reply_sender.sv
  - design/cmd_decode_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_cmd_decode.sv

/* verif/tb_cmd_decode.sv */
// Self-checking testbench for the command decoder, simulated as the top module on its own
module tb_cmd_decode;

   localparam int REPLY_TIMEOUT = 40;
   localparam int QUIET_CYCLES  = 30;

   logic        clk;
   logic        rst_n;
   logic        rx_vd;
   logic        rx_sop;
   logic        rx_eop;
   logic [15:0] rx_data;
   logic [7:0]  io_in;
   logic [7:0]  io_dir;
   logic [7:0]  io_db;
   logic [7:0]  io_bank;
   logic        tx_vd;
   logic [8:0]  tx_addr;
   logic [15:0] tx_data;
   logic        tx_eop;

   // Model of the held pattern and of the IO outputs
   logic [7:0]  m_mask;
   logic [7:0]  m_dir;
   logic [7:0]  m_data;
   logic [7:0]  m_io_dir;
   logic [7:0]  m_io_db;
   logic [7:0]  m_io_bank;

   logic [15:0] msg_q[$];
   logic [15:0] exp_data_q[$];
   logic [8:0]  exp_addr_q[$];
   logic        exp_eop_q[$];
   logic [31:0] rng_state;
   int          eop_cnt;
   int          mismatch_cnt;
   int          fail_cnt;

   tb_clock_gen #(.PERIOD(8)) u_clk (.clk(clk));

   cmd_decode_top UUT (
      .clk       (clk),
      .i_rst_n   (rst_n),
      .i_rx_vd   (rx_vd),
      .i_rx_sop  (rx_sop),
      .i_rx_eop  (rx_eop),
      .i_rx_data (rx_data),
      .i_io_db   (io_in),
      .o_io_dir  (io_dir),
      .o_io_db   (io_db),
      .o_io_bank (io_bank),
      .o_tx_vd   (tx_vd),
      .o_tx_addr (tx_addr),
      .o_tx_data (tx_data),
      .o_tx_eop  (tx_eop)
   );

   //////////////////////////////////////////////////////////////////////
   // Helpers and reference model
   //////////////////////////////////////////////////////////////////////
   // First character goes in the low byte
   function automatic logic [15:0] txt(input logic [7:0] c0, input logic [7:0] c1);
      return {c1, c0};
   endfunction

   function automatic logic [7:0] hex_char(input logic [3:0] n);
      return (n < 4'd10) ? 8'h30 + n : 8'h37 + n;
   endfunction

   function automatic logic [15:0] hex_word(input logic [7:0] b);
      return txt(hex_char(b[7:4]), hex_char(b[3:0]));
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic void push_exp(input logic [15:0] w, input logic [8:0] a, input logic e);
      exp_data_q.push_back(w);
      exp_addr_q.push_back(a);
      exp_eop_q.push_back(e);
   endfunction

   // Expected reply words and IO outputs for one complete message
   function automatic void predict(input logic [15:0] typ, input logic [15:0] mode,
                                   input int nbytes, input logic bad,
                                   input logic [23:0] pat, input logic [7:0] ch,
                                   input logic [7:0] pins);
      logic [15:0] pf;
      logic [15:0] code;
      logic [7:0]  c_mask;
      logic [7:0]  c_dir;
      logic [7:0]  c_data;
      logic        full_ok;
      c_mask  = pat[23:16];
      c_dir   = pat[15:8] & ~c_mask;
      c_data  = (pat[7:0] & c_dir) | (pins & ~c_dir & ~c_mask);
      full_ok = (nbytes == 3) && !bad;
      pf      = txt("F", "A");
      if (typ == txt("0", "0")) begin
         push_exp(txt("#", "#"), 9'h000, 1'b0);
         push_exp(typ, 9'h001, 1'b0);
         push_exp(txt("P", "A"), 9'h002, 1'b0);
         push_exp(txt("0", "1"), 9'h003, 1'b1);
      end else if (typ == txt("0", "2")) begin
         case (mode)
            txt("0", "1"): code = (nbytes != 3) ? txt("0", "2") :
                                  (bad ? txt("0", "3") : txt("0", "1"));
            txt("0", "2"): code = (nbytes == 0) ? txt("1", "1") : txt("1", "2");
            txt("0", "3"): code = (nbytes != 3) ? txt("2", "2") :
                                  (bad ? txt("2", "3") : txt("2", "1"));
            default:       code = txt("0", "0");
         endcase
         if (full_ok && (mode == txt("0", "1") || mode == txt("0", "3"))) begin
            m_mask = c_mask;
            m_dir  = c_dir;
            m_data = c_data;
            pf     = txt("P", "A");
         end
         if ((mode == txt("0", "2") && nbytes == 0) || (mode == txt("0", "3") && full_ok)) begin
            m_io_dir  = m_dir;
            m_io_db   = m_data & ~m_mask;
            m_io_bank = ch;
            pf        = txt("P", "A");
         end
         push_exp(txt("#", "#"), 9'h100, 1'b0);
         push_exp(typ, 9'h101, 1'b0);
         push_exp(pf, 9'h102, 1'b0);
         push_exp(code, 9'h103, 1'b0);
         push_exp(hex_word(m_mask), 9'h104, 1'b0);
         push_exp(hex_word(m_dir), 9'h105, 1'b0);
         push_exp(hex_word(m_data), 9'h106, 1'b0);
         push_exp(txt(8'h0d, 8'h0a), 9'h107, 1'b1);
      end
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Reply comparison on each valid word
   //////////////////////////////////////////////////////////////////////
   always @(negedge clk) begin : check_tx
      logic [15:0] e_data;
      logic [8:0]  e_addr;
      logic        e_eop;
      if (tx_vd) begin
         if (exp_data_q.size() == 0) begin
            $display("unexpected reply word %h at address %h", tx_data, tx_addr);
            fail_cnt++;
         end else begin
            e_data = exp_data_q.pop_front();
            e_addr = exp_addr_q.pop_front();
            e_eop  = exp_eop_q.pop_front();
            if (tx_data !== e_data) begin
               $display("mismatch o_tx_data: got %h expected %h", tx_data, e_data);
               mismatch_cnt++;
            end
            if (tx_addr !== e_addr) begin
               $display("mismatch o_tx_addr: got %h expected %h", tx_addr, e_addr);
               mismatch_cnt++;
            end
            if (tx_eop !== e_eop) begin
               $display("mismatch o_tx_eop: got %h expected %h", tx_eop, e_eop);
               mismatch_cnt++;
            end
         end
         if (tx_eop) begin
            eop_cnt++;
         end
      end
   end

   task automatic check_io();
      if (io_dir !== m_io_dir) begin
         $display("mismatch o_io_dir: got %h expected %h", io_dir, m_io_dir);
         mismatch_cnt++;
      end
      if (io_db !== m_io_db) begin
         $display("mismatch o_io_db: got %h expected %h", io_db, m_io_db);
         mismatch_cnt++;
      end
      if (io_bank !== m_io_bank) begin
         $display("mismatch o_io_bank: got %h expected %h", io_bank, m_io_bank);
         mismatch_cnt++;
      end
   endtask

   // Sends the queued words framed by sop and eop, then waits for the reply or a quiet window
   task automatic exchange(input logic with_end, input logic want_reply);
      int mark;
      int wait_n;
      int i;
      mark   = eop_cnt;
      wait_n = 0;
      @(posedge clk);
      rx_sop <= 1'b1;
      for (i = 0; i < msg_q.size(); i++) begin
         @(posedge clk);
         rx_sop  <= 1'b0;
         rx_vd   <= 1'b1;
         rx_data <= msg_q[i];
         rx_eop  <= !with_end && (i == msg_q.size() - 1);
      end
      if (with_end) begin
         @(posedge clk);
         rx_data <= txt(8'h0d, 8'h0a);
         rx_eop  <= 1'b1;
      end
      @(posedge clk);
      rx_vd  <= 1'b0;
      rx_eop <= 1'b0;
      msg_q.delete();
      if (want_reply) begin
         while (eop_cnt == mark && wait_n < REPLY_TIMEOUT) begin
            @(posedge clk);
            wait_n++;
         end
         if (eop_cnt == mark) begin
            $display("no reply arrived within %0d cycles", REPLY_TIMEOUT);
            fail_cnt++;
         end
      end else begin
         while (wait_n < QUIET_CYCLES) begin
            @(posedge clk);
            wait_n++;
         end
      end
      if (exp_data_q.size() != 0) begin
         $display("reply ended with %0d expected words missing", exp_data_q.size());
         fail_cnt++;
         exp_data_q.delete();
         exp_addr_q.delete();
         exp_eop_q.delete();
      end
      @(negedge clk);
      check_io();
   endtask

   // One message with random channel, pattern bytes and IO inputs
   task automatic run_msg(input logic [15:0] typ, input logic [15:0] mode,
                          input int nbytes, input logic bad, input logic want_reply);
      logic [31:0] r;
      logic [31:0] p;
      logic [23:0] pat;
      int          k;
      r   = next_rand();
      p   = next_rand();
      pat = p[23:0];
      @(posedge clk);
      io_in <= r[15:8];
      predict(typ, mode, nbytes, bad, pat, r[7:0], r[15:8]);
      msg_q.push_back(txt("#", "#"));
      msg_q.push_back(typ);
      if (mode != 16'h0) begin
         msg_q.push_back(mode);
         msg_q.push_back(hex_word(r[7:0]));
      end
      for (k = 0; k < nbytes; k++) begin
         // Bad character in the first data word, so the error flag must stay set
         if (bad && k == 0) begin
            msg_q.push_back(txt("G", "3"));
         end else begin
            msg_q.push_back(hex_word(pat[23 - 8 * k -: 8]));
         end
      end
      exchange(1'b1, want_reply);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      rng_state    = 32'hbc8d_6ab3;
      eop_cnt      = 0;
      mismatch_cnt = 0;
      fail_cnt     = 0;
      m_mask       = '0;
      m_dir        = '0;
      m_data       = '0;
      m_io_dir     = '0;
      m_io_db      = '0;
      m_io_bank    = '0;
      rst_n   <= 1'b0;
      rx_vd   <= 1'b0;
      rx_sop  <= 1'b0;
      rx_eop  <= 1'b0;
      rx_data <= '0;
      io_in   <= '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      run_msg(txt("0", "0"), 16'h0, 0, 1'b0, 1'b1);
      run_msg(txt("0", "2"), txt("0", "1"), 3, 1'b0, 1'b1);
      run_msg(txt("0", "2"), txt("0", "1"), 3, 1'b0, 1'b1);
      run_msg(txt("0", "2"), txt("0", "2"), 0, 1'b0, 1'b1);
      run_msg(txt("0", "2"), txt("0", "2"), 1, 1'b0, 1'b1);
      run_msg(txt("0", "2"), txt("0", "3"), 3, 1'b0, 1'b1);
      run_msg(txt("0", "2"), txt("0", "3"), 3, 1'b1, 1'b1);
      run_msg(txt("0", "2"), txt("0", "3"), 2, 1'b0, 1'b1);
      // Held pattern must have survived the failed SEX messages
      run_msg(txt("0", "2"), txt("0", "2"), 0, 1'b0, 1'b1);
      run_msg(txt("0", "2"), txt("0", "9"), 0, 1'b0, 1'b1);
      run_msg(txt("0", "5"), txt("0", "1"), 3, 1'b0, 1'b0);

      // Aborted by eop on the channel word
      msg_q.push_back(txt("#", "#"));
      msg_q.push_back(txt("0", "2"));
      msg_q.push_back(txt("0", "3"));
      msg_q.push_back(hex_word(8'h5a));
      exchange(1'b0, 1'b0);

      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* verif/tb_clock_gen.sv */
// Free-running testbench clock source, instantiated once by the command decoder testbench
module tb_clock_gen #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

endmodule

/* design/cmd_decode_top.sv */
// Command decoder top level joining parser, executor and reply sender to the host link
module cmd_decode_top (
   input  logic                           clk,
   input  logic                           i_rst_n,
   input  logic                           i_rx_vd,
   input  logic                           i_rx_sop,
   input  logic                           i_rx_eop,
   input  cmd_pkg::word_t                 i_rx_data,
   input  cmd_pkg::io_t                   i_io_db,
   output cmd_pkg::io_t                   o_io_dir,
   output cmd_pkg::io_t                   o_io_db,
   output logic [cmd_pkg::BANK_NBIT-1:0]  o_io_bank,
   output logic                           o_tx_vd,
   output logic [cmd_pkg::TX_ADDR_NBIT:0] o_tx_addr,
   output cmd_pkg::word_t                 o_tx_data,
   output logic                           o_tx_eop
);

   msg_if   u_msg ();
   reply_if u_reply ();

   msg_parser u_parser (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_rx_vd   (i_rx_vd),
      .i_rx_sop  (i_rx_sop),
      .i_rx_eop  (i_rx_eop),
      .i_rx_data (i_rx_data),
      .o_msg     (u_msg.parser)
   );

   cmd_exec u_exec (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_msg     (u_msg.exec),
      .i_io_db   (i_io_db),
      .o_io_dir  (o_io_dir),
      .o_io_db   (o_io_db),
      .o_io_bank (o_io_bank),
      .o_reply   (u_reply.exec)
   );

   reply_sender u_sender (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_reply   (u_reply.sender),
      .o_tx_vd   (o_tx_vd),
      .o_tx_addr (o_tx_addr),
      .o_tx_data (o_tx_data),
      .o_tx_eop  (o_tx_eop)
   );

endmodule

/* design/reply_sender.sv */
// Transmit FSM with word counter that streams the reply words to the host link
module reply_sender (
   input  logic                           clk,
   input  logic                           i_rst_n,
   reply_if.sender                        i_reply,
   output logic                           o_tx_vd,
   output logic [cmd_pkg::TX_ADDR_NBIT:0] o_tx_addr,
   output cmd_pkg::word_t                 o_tx_data,
   output logic                           o_tx_eop
);

   cmd_pkg::tx_state_e                  state_q;
   logic [cmd_pkg::TX_ADDR_NBIT-1:0]    idx_q;
   logic                                base_q;
   cmd_pkg::word_t                      type_q;
   cmd_pkg::word_t                      pf_q;
   cmd_pkg::word_t                      code_q;
   logic [cmd_pkg::MSG_DATA_NBIT-1:0]   pat_q;
   cmd_pkg::word_t                      enc_word;

   // Pattern bytes leave top first: mask, dir, data
   ascii_hex_encode u_enc (
      .i_byte (pat_q[cmd_pkg::MSG_DATA_NBIT-1 -: 8]),
      .o_word (enc_word)
   );

   assign o_tx_addr = {base_q, idx_q};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q   <= cmd_pkg::TX_IDLE;
         idx_q     <= '0;
         base_q    <= 1'b0;
         type_q    <= '0;
         pf_q      <= '0;
         code_q    <= '0;
         pat_q     <= '0;
         o_tx_vd   <= 1'b0;
         o_tx_data <= '0;
         o_tx_eop  <= 1'b0;
      end else begin
         o_tx_vd  <= 1'b0;
         o_tx_eop <= 1'b0;
         case (state_q)
            cmd_pkg::TX_IDLE: begin
               if (i_reply.start) begin
                  type_q  <= i_reply.msg_type;
                  pf_q    <= i_reply.pf;
                  code_q  <= i_reply.code;
                  pat_q   <= {i_reply.io_mask, i_reply.io_dir, i_reply.io_data};
                  base_q  <= (i_reply.msg_type != cmd_pkg::TYPE_HANDSHAKE);
                  state_q <= cmd_pkg::TX_HEAD;
               end
            end
            cmd_pkg::TX_HEAD: begin
               o_tx_vd   <= 1'b1;
               o_tx_data <= cmd_pkg::MSG_HEAD;
               idx_q     <= '0;
               state_q   <= cmd_pkg::TX_TYPE;
            end
            cmd_pkg::TX_TYPE: begin
               o_tx_vd   <= 1'b1;
               o_tx_data <= type_q;
               idx_q     <= idx_q + 1'b1;
               state_q   <= cmd_pkg::TX_PF;
            end
            cmd_pkg::TX_PF: begin
               o_tx_vd   <= 1'b1;
               o_tx_data <= pf_q;
               idx_q     <= idx_q + 1'b1;
               state_q   <= cmd_pkg::TX_CODE;
            end
            cmd_pkg::TX_CODE: begin
               o_tx_vd   <= 1'b1;
               o_tx_data <= code_q;
               idx_q     <= idx_q + 1'b1;
               // Handshake reply ends on its code word
               if (base_q) begin
                  state_q <= cmd_pkg::TX_DATA;
               end else begin
                  o_tx_eop <= 1'b1;
                  state_q  <= cmd_pkg::TX_IDLE;
               end
            end
            cmd_pkg::TX_DATA: begin
               o_tx_vd   <= 1'b1;
               o_tx_data <= enc_word;
               idx_q     <= idx_q + 1'b1;
               pat_q     <= pat_q << 8;
               // Code word sits at index 3, data words follow it
               if (idx_q == cmd_pkg::IO_DATA_NUM + 2) begin
                  state_q <= cmd_pkg::TX_END;
               end
            end
            cmd_pkg::TX_END: begin
               o_tx_vd   <= 1'b1;
               o_tx_data <= cmd_pkg::MSG_END;
               o_tx_eop  <= 1'b1;
               idx_q     <= idx_q + 1'b1;
               state_q   <= cmd_pkg::TX_IDLE;
            end
            default: state_q <= cmd_pkg::TX_IDLE;
         endcase
      end
   end

endmodule

/* design/cmd_exec.sv */
// Evaluates a received message, keeps the IO pattern, drives the IO bank and requests a reply
module cmd_exec (
   input  logic                          clk,
   input  logic                          i_rst_n,
   msg_if.exec                           i_msg,
   input  cmd_pkg::io_t                  i_io_db,
   output cmd_pkg::io_t                  o_io_dir,
   output cmd_pkg::io_t                  o_io_db,
   output logic [cmd_pkg::BANK_NBIT-1:0] o_io_bank,
   reply_if.exec                         o_reply
);

   cmd_pkg::io_t   cand_mask;
   cmd_pkg::io_t   cand_dir;
   cmd_pkg::io_t   cand_data;
   cmd_pkg::io_t   hold_mask;
   cmd_pkg::io_t   hold_dir;
   cmd_pkg::io_t   hold_data;
   logic           reply_en;
   logic           set_en;
   logic           exe_en;
   logic           cnt_full;
   cmd_pkg::word_t pf;
   cmd_pkg::word_t code;

   // Candidate pattern, masked bits behave as tri-stated inputs
   assign cand_mask = i_msg.data[23:16];
   assign cand_dir  = i_msg.data[15:8] & ~cand_mask;
   assign cand_data = (cand_dir & i_msg.data[7:0]) | (~cand_dir & ~cand_mask & i_io_db);

   assign cnt_full = (i_msg.byte_cnt == cmd_pkg::IO_DATA_NUM);

   always_comb begin
      reply_en = 1'b0;
      set_en   = 1'b0;
      exe_en   = 1'b0;
      pf       = cmd_pkg::MSG_FAIL;
      code     = cmd_pkg::CODE_BAD_MODE;
      if (i_msg.done && i_msg.msg_type == cmd_pkg::TYPE_HANDSHAKE) begin
         reply_en = 1'b1;
         pf       = cmd_pkg::MSG_PASS;
         code     = cmd_pkg::CODE_SET_OK;
      end else if (i_msg.done && i_msg.msg_type == cmd_pkg::TYPE_IOCTRL) begin
         reply_en = 1'b1;
         case (i_msg.mode)
            cmd_pkg::MODE_SET: begin
               set_en = cnt_full & ~i_msg.err;
               code   = !cnt_full ? cmd_pkg::CODE_SET_LEN :
                        i_msg.err ? cmd_pkg::CODE_SET_ERR : cmd_pkg::CODE_SET_OK;
            end
            cmd_pkg::MODE_EXE: begin
               exe_en = (i_msg.byte_cnt == '0);
               code   = exe_en ? cmd_pkg::CODE_EXE_OK : cmd_pkg::CODE_EXE_LEN;
            end
            cmd_pkg::MODE_SEX: begin
               set_en = cnt_full & ~i_msg.err;
               exe_en = set_en;
               code   = !cnt_full ? cmd_pkg::CODE_SEX_LEN :
                        i_msg.err ? cmd_pkg::CODE_SEX_ERR : cmd_pkg::CODE_SEX_OK;
            end
            default: code = cmd_pkg::CODE_BAD_MODE;
         endcase
         if (set_en || exe_en) begin
            pf = cmd_pkg::MSG_PASS;
         end
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_reply.start    <= 1'b0;
         o_reply.msg_type <= '0;
         o_reply.pf       <= '0;
         o_reply.code     <= '0;
         hold_mask        <= '0;
         hold_dir         <= '0;
         hold_data        <= '0;
         o_io_dir         <= '0;
         o_io_db          <= '0;
         o_io_bank        <= '0;
      end else begin
         o_reply.start <= reply_en;
         if (reply_en) begin
            o_reply.msg_type <= i_msg.msg_type;
            o_reply.pf       <= pf;
            o_reply.code     <= code;
         end
         if (set_en) begin
            hold_mask <= cand_mask;
            hold_dir  <= cand_dir;
            hold_data <= cand_data;
         end
         // SEX drives the new pattern, EXE the stored one
         if (exe_en) begin
            o_io_dir  <= set_en ? cand_dir : hold_dir;
            o_io_db   <= set_en ? (cand_data & ~cand_mask) : (hold_data & ~hold_mask);
            o_io_bank <= i_msg.ch_addr;
         end
      end
   end

   // Pattern registers update on the same edge as start
   assign o_reply.io_mask = hold_mask;
   assign o_reply.io_dir  = hold_dir;
   assign o_reply.io_data = hold_data;

endmodule

/* design/msg_parser.sv */
// Receive FSM that frames host messages and collects type, mode, address and data bytes
module msg_parser (
   input  logic           clk,
   input  logic           i_rst_n,
   input  logic           i_rx_vd,
   input  logic           i_rx_sop,
   input  logic           i_rx_eop,
   input  cmd_pkg::word_t i_rx_data,
   msg_if.parser          o_msg
);

   cmd_pkg::rx_state_e state_q;
   logic [7:0]         dec_byte;
   logic               dec_err;
   logic               end_word;

   ascii_hex_decode u_dec (
      .i_word (i_rx_data),
      .o_byte (dec_byte),
      .o_err  (dec_err)
   );

   // CR or LF in the first character closes the message
   assign end_word = i_rx_vd &&
                     (i_rx_data[7:0] == cmd_pkg::CHAR_CR || i_rx_data[7:0] == cmd_pkg::CHAR_LF);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q        <= cmd_pkg::RX_IDLE;
         o_msg.done     <= 1'b0;
         o_msg.msg_type <= '0;
         o_msg.mode     <= '0;
         o_msg.ch_addr  <= '0;
         o_msg.data     <= '0;
         o_msg.byte_cnt <= '0;
         o_msg.err      <= 1'b0;
      end else begin
         o_msg.done <= 1'b0;
         case (state_q)
            cmd_pkg::RX_IDLE: begin
               if (i_rx_sop) begin
                  // Skipped fields read as zero
                  o_msg.msg_type <= '0;
                  o_msg.mode     <= '0;
                  o_msg.ch_addr  <= '0;
                  o_msg.data     <= '0;
                  o_msg.byte_cnt <= '0;
                  o_msg.err      <= 1'b0;
                  state_q        <= cmd_pkg::RX_HEAD;
               end
            end
            cmd_pkg::RX_HEAD: begin
               if (i_rx_eop) begin
                  state_q <= cmd_pkg::RX_IDLE;
               end else if (i_rx_vd && i_rx_data == cmd_pkg::MSG_HEAD) begin
                  state_q <= cmd_pkg::RX_TYPE;
               end
            end
            cmd_pkg::RX_TYPE: begin
               if (i_rx_eop) begin
                  state_q <= cmd_pkg::RX_IDLE;
               end else if (i_rx_vd) begin
                  o_msg.msg_type <= i_rx_data;
                  state_q        <= cmd_pkg::RX_MODE;
               end
            end
            cmd_pkg::RX_MODE, cmd_pkg::RX_CHADDR, cmd_pkg::RX_DATA: begin
               // An end word still counts when eop rides along with it
               if (end_word) begin
                  state_q <= cmd_pkg::RX_END;
               end else if (i_rx_eop) begin
                  state_q <= cmd_pkg::RX_IDLE;
               end else if (i_rx_vd) begin
                  if (state_q == cmd_pkg::RX_MODE) begin
                     o_msg.mode <= i_rx_data;
                     state_q    <= cmd_pkg::RX_CHADDR;
                  end else if (state_q == cmd_pkg::RX_CHADDR) begin
                     o_msg.ch_addr <= dec_byte;
                     o_msg.err     <= o_msg.err | dec_err;
                     state_q       <= cmd_pkg::RX_DATA;
                  end else begin
                     o_msg.data <= {o_msg.data[cmd_pkg::MSG_DATA_NBIT-9:0], dec_byte};
                     o_msg.err  <= o_msg.err | dec_err;
                     // Saturate so long messages never wrap back to a legal count
                     if (o_msg.byte_cnt != '1) begin
                        o_msg.byte_cnt <= o_msg.byte_cnt + 1'b1;
                     end
                  end
               end
            end
            cmd_pkg::RX_END: begin
               o_msg.done <= 1'b1;
               state_q    <= cmd_pkg::RX_IDLE;
            end
            default: state_q <= cmd_pkg::RX_IDLE;
         endcase
      end
   end

endmodule

/* design/ascii_hex_encode.sv */
// Turns a byte into two upper-case hex characters, high nibble first in the low byte
module ascii_hex_encode (
   input  logic [7:0]     i_byte,
   output cmd_pkg::word_t o_word
);

   function automatic logic [7:0] nib_char(input logic [3:0] n);
      logic [7:0] c;
      if (n <= 4'd9) begin
         c = {4'h3, n};
      end else begin
         // 10 maps to 'A' (0x41)
         c = {4'h4, n - 4'd9};
      end
      return c;
   endfunction

   assign o_word = {nib_char(i_byte[3:0]), nib_char(i_byte[7:4])};

endmodule

/* design/ascii_hex_decode.sv */
// Turns a two-character hex word into a byte and flags any non-hex character
module ascii_hex_decode (
   input  cmd_pkg::word_t i_word,
   output logic [7:0]     o_byte,
   output logic           o_err
);

   // Returns {err, nibble}
   function automatic logic [4:0] char_val(input logic [7:0] c);
      logic [4:0] r;
      if (c >= "0" && c <= "9") begin
         r = {1'b0, c[3:0]};
      end else if ((c >= "a" && c <= "f") || (c >= "A" && c <= "F")) begin
         // Both letter ranges start at 1 in the low nibble
         r = {1'b0, c[3:0] + 4'd9};
      end else begin
         r = 5'b1_0000;
      end
      return r;
   endfunction

   logic [4:0] hi_val;
   logic [4:0] lo_val;

   // Low byte carries the first character, the high nibble
   assign hi_val = char_val(i_word[7:0]);
   assign lo_val = char_val(i_word[15:8]);

   assign o_byte = {hi_val[3:0], lo_val[3:0]};
   assign o_err  = hi_val[4] | lo_val[4];

endmodule

/* design/reply_if.sv */
// Reply request from the executor to the sender, all fields valid with the start strobe
interface reply_if;

   logic           start;
   cmd_pkg::word_t msg_type;
   cmd_pkg::word_t pf;
   cmd_pkg::word_t code;
   cmd_pkg::io_t   io_mask;
   cmd_pkg::io_t   io_dir;
   cmd_pkg::io_t   io_data;

   modport exec   (output start, msg_type, pf, code, io_mask, io_dir, io_data);
   modport sender (input  start, msg_type, pf, code, io_mask, io_dir, io_data);

endinterface

/* design/msg_if.sv */
// Received message handed from the parser to the executor, one done strobe per message
interface msg_if;

   logic                               done;
   cmd_pkg::word_t                     msg_type;
   cmd_pkg::word_t                     mode;
   logic [cmd_pkg::BANK_NBIT-1:0]      ch_addr;
   logic [cmd_pkg::MSG_DATA_NBIT-1:0]  data;
   logic [cmd_pkg::CNT_NBIT-1:0]       byte_cnt;
   logic                               err;

   modport parser (output done, msg_type, mode, ch_addr, data, byte_cnt, err);
   modport exec   (input  done, msg_type, mode, ch_addr, data, byte_cnt, err);

endinterface

/* design/cmd_pkg.sv */
// Shared widths, character codes, message codes and state types for the command decoder
package cmd_pkg;

   ////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////
   localparam int WORD_NBIT     = 16;
   localparam int IO_NBIT       = 8;
   localparam int TX_ADDR_NBIT  = 8;
   localparam int BANK_NBIT     = 8;
   localparam int IO_DATA_NUM   = 3;
   localparam int MSG_DATA_NBIT = 24;
   localparam int CNT_NBIT      = 4;

   typedef logic [WORD_NBIT-1:0] word_t;
   typedef logic [IO_NBIT-1:0]   io_t;

   ////////////////////////////////////////////////////////////////////
   // Character words
   ////////////////////////////////////////////////////////////////////
   // First character of a word sits in the low byte
   localparam word_t MSG_HEAD  = {"#", "#"};
   localparam logic [7:0] CHAR_CR = 8'h0d;
   localparam logic [7:0] CHAR_LF = 8'h0a;
   localparam word_t MSG_END   = {CHAR_LF, CHAR_CR};

   // Message types
   localparam word_t TYPE_HANDSHAKE = {"0", "0"};
   localparam word_t TYPE_IOCTRL    = {"2", "0"};

   // Modes
   localparam word_t MODE_SET = {"1", "0"};
   localparam word_t MODE_EXE = {"2", "0"};
   localparam word_t MODE_SEX = {"3", "0"};

   // Pass/fail words
   localparam word_t MSG_PASS = {"A", "P"};
   localparam word_t MSG_FAIL = {"A", "F"};

   // Reply codes
   localparam word_t CODE_BAD_MODE = {"0", "0"};
   localparam word_t CODE_SET_OK   = {"1", "0"};
   localparam word_t CODE_SET_LEN  = {"2", "0"};
   localparam word_t CODE_SET_ERR  = {"3", "0"};
   localparam word_t CODE_EXE_OK   = {"1", "1"};
   localparam word_t CODE_EXE_LEN  = {"2", "1"};
   localparam word_t CODE_SEX_OK   = {"1", "2"};
   localparam word_t CODE_SEX_LEN  = {"2", "2"};
   localparam word_t CODE_SEX_ERR  = {"3", "2"};

   ////////////////////////////////////////////////////////////////////
   // State encodings
   ////////////////////////////////////////////////////////////////////
   typedef enum logic [2:0] {
      RX_IDLE, RX_HEAD, RX_TYPE, RX_MODE, RX_CHADDR, RX_DATA, RX_END
   } rx_state_e;

   typedef enum logic [2:0] {
      TX_IDLE, TX_HEAD, TX_TYPE, TX_PF, TX_CODE, TX_DATA, TX_END
   } tx_state_e;

endpackage
